// File: hdl/kbdPkg.sv
package kbdPkg;

    // --------------------------------------------------
    // PS/2 set 2 prefix bytes
    // --------------------------------------------------
    localparam logic [7:0] extCode = 8'hE0;          // Extended key follows
    localparam logic [7:0] rlsCode = 8'hF0;          // Break code follows

    localparam int numRows    = 8;                   // Z88 rows A8..A15
    localparam int keysPerRow = 8;                   // Columns D0..D7

    // How a table entry treats the E0 prefix
    typedef enum logic [1:0] {
        extPlain,                                    // Only without E0
        extOnly,                                     // Only with E0
        extAny                                       // Either way
    } extMode;

    typedef struct packed {
        logic [7:0] code;                            // Set 2 make code
        extMode     mode;
    } keyEntry;

    // --------------------------------------------------
    // Z88 key map, index is row * 8 + column
    // --------------------------------------------------
    localparam keyEntry keyMap [numRows * keysPerRow] = '{
        // A8: 8 7 N H Y 6 Enter Del
        '{8'h3E, extPlain}, '{8'h3D, extPlain}, '{8'h31, extPlain}, '{8'h33, extPlain},
        '{8'h35, extPlain}, '{8'h36, extPlain}, '{8'h5A, extPlain}, '{8'h66, extPlain},
        // A9: I U B G T 5 Up Backslash
        '{8'h43, extPlain}, '{8'h3C, extPlain}, '{8'h32, extPlain}, '{8'h34, extPlain},
        '{8'h2C, extPlain}, '{8'h2E, extPlain}, '{8'h75, extOnly},  '{8'h5D, extPlain},
        // A10: O J V F R 4 Down =
        '{8'h44, extPlain}, '{8'h3B, extPlain}, '{8'h2A, extPlain}, '{8'h2B, extPlain},
        '{8'h2D, extPlain}, '{8'h25, extPlain}, '{8'h72, extOnly},  '{8'h55, extPlain},
        // A11: 9 K C D E 3 Right -
        '{8'h46, extPlain}, '{8'h42, extPlain}, '{8'h21, extPlain}, '{8'h23, extPlain},
        '{8'h24, extPlain}, '{8'h26, extPlain}, '{8'h74, extOnly},  '{8'h4E, extPlain},
        // A12: P M X S W 2 Left ]
        '{8'h4D, extPlain}, '{8'h3A, extPlain}, '{8'h22, extPlain}, '{8'h1B, extPlain},
        '{8'h1D, extPlain}, '{8'h1E, extPlain}, '{8'h6B, extOnly},  '{8'h5B, extPlain},
        // A13: 0 L Z A Q 1 Space [
        '{8'h45, extPlain}, '{8'h4B, extPlain}, '{8'h1A, extPlain}, '{8'h1C, extPlain},
        '{8'h15, extPlain}, '{8'h16, extPlain}, '{8'h29, extPlain}, '{8'h54, extPlain},
        // A14: Quote ; , Menu(F3) Diamond(Ctrl) Tab LShift Help(F1)
        '{8'h52, extPlain}, '{8'h4C, extPlain}, '{8'h41, extPlain}, '{8'h04, extPlain},
        '{8'h14, extAny},   '{8'h0D, extPlain}, '{8'h12, extPlain}, '{8'h05, extPlain},
        // A15: Pound / . Caps Index(F2) Esc Square(Alt) RShift
        '{8'h0E, extPlain}, '{8'h4A, extPlain}, '{8'h49, extPlain}, '{8'h58, extPlain},
        '{8'h06, extPlain}, '{8'h76, extPlain}, '{8'h11, extAny},   '{8'h59, extPlain}
    };

endpackage

// File: hdl/ps2FrameRx.sv
`timescale 1ns/1ps

module ps2FrameRx #(
    parameter int SYNC_STAGES    = 3,                // At least two stages
    parameter int TIMEOUT_CYCLES = 2000
) (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       ps2clk,
    input  logic       ps2dat,
    output logic [7:0] rxByte,
    output logic       rxValid
);

    localparam int IDLE_W = $clog2(TIMEOUT_CYCLES + 1);

    logic [SYNC_STAGES-1:0] clkSync;
    logic [SYNC_STAGES-1:0] datSync;
    logic                   clkPrev;
    logic                   ps2Rise;
    logic                   datBit;
    logic [10:0]            shiftReg;
    logic [10:0]            frameNext;
    logic [3:0]             bitCount;
    logic [IDLE_W-1:0]      idleCount;
    logic                   frameOk;

    // --------------------------------------------------
    // Synchronizers and edge detect
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            clkSync <= '1;                           // Lines idle high
            datSync <= '1;
            clkPrev <= 1'b1;
        end else begin
            clkSync <= {clkSync[SYNC_STAGES-2:0], ps2clk};
            datSync <= {datSync[SYNC_STAGES-2:0], ps2dat};
            clkPrev <= clkSync[SYNC_STAGES-1];
        end
    end

    assign ps2Rise = clkSync[SYNC_STAGES-1] & ~clkPrev;
    assign datBit  = datSync[SYNC_STAGES-1];

    // Frame arrives LSB first, start bit ends up in bit 0
    assign frameNext = {datBit, shiftReg[10:1]};
    assign frameOk   = !frameNext[0] && frameNext[10] && (^frameNext[9:1]);

    // --------------------------------------------------
    // Bit counter and stall watchdog
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            bitCount  <= '0;
            idleCount <= '0;
            rxValid   <= 1'b0;
        end else begin
            rxValid <= 1'b0;
            if (ps2Rise) begin
                idleCount <= '0;
                if (bitCount == 4'd10) begin          // Stop bit
                    bitCount <= '0;
                    rxValid  <= frameOk;
                end else begin
                    bitCount <= bitCount + 4'd1;
                end
            end else if (bitCount != '0) begin
                if (idleCount == IDLE_W'(TIMEOUT_CYCLES - 1)) begin
                    bitCount  <= '0;                  // Abandon partial frame
                    idleCount <= '0;
                end else begin
                    idleCount <= idleCount + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ps2Rise) begin
            shiftReg <= frameNext;
            if (bitCount == 4'd10) begin
                rxByte <= frameNext[8:1];
            end
        end
    end

    // A frame takes far longer than one clk, so pulses never touch
    assert property (@(posedge clk) disable iff (!reset_n) rxValid |=> !rxValid)
        else $error("rxValid high on two consecutive cycles");

endmodule

// File: hdl/scanDecoder.sv
`timescale 1ns/1ps

module scanDecoder (
    input  logic       clk,
    input  logic       reset_n,
    input  logic [7:0] rxByte,
    input  logic       rxValid,
    output logic [7:0] keyCode,
    output logic       keyExt,
    output logic       keyRelease,
    output logic       keyValid
);

    logic extPend;                                   // E0 seen
    logic rlsPend;                                   // F0 seen

    // --------------------------------------------------
    // Prefix tracking
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            extPend  <= 1'b0;
            rlsPend  <= 1'b0;
            keyValid <= 1'b0;
        end else begin
            keyValid <= 1'b0;
            if (rxValid) begin
                if (rxByte == kbdPkg::extCode) begin
                    extPend <= 1'b1;                 // Also after F0
                end else if (rxByte == kbdPkg::rlsCode) begin
                    rlsPend <= 1'b1;
                end else begin
                    keyValid <= 1'b1;
                    extPend  <= 1'b0;
                    rlsPend  <= 1'b0;
                end
            end
        end
    end

    // Key event payload
    always_ff @(posedge clk) begin
        if (rxValid && rxByte != kbdPkg::extCode && rxByte != kbdPkg::rlsCode) begin
            keyCode    <= rxByte;
            keyExt     <= extPend;
            keyRelease <= rlsPend;
        end
    end

    // Prefix bytes must never reach the rows as keys
    assert property (@(posedge clk) disable iff (!reset_n)
        keyValid |-> (keyCode != kbdPkg::extCode && keyCode != kbdPkg::rlsCode))
        else $error("keyValid carried a prefix byte");

endmodule

// File: hdl/matrixRow.sv
`timescale 1ns/1ps

module matrixRow #(
    parameter int ROW = 0                            // Row index, 0 is A8
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic [7:0]                    keyCode,
    input  logic                          keyExt,
    input  logic                          keyRelease,
    input  logic                          keyValid,
    output logic [kbdPkg::keysPerRow-1:0] pressed
);

    localparam int BASE = ROW * kbdPkg::keysPerRow;   // First table entry of this row

    // Does the E0 state of the event fit the entry
    function automatic logic extAccepts(kbdPkg::extMode mode, logic ext);
        case (mode)
            kbdPkg::extPlain: return !ext;
            kbdPkg::extOnly:  return ext;
            kbdPkg::extAny:   return 1'b1;
            default:          return 1'b0;
        endcase
    endfunction

    // --------------------------------------------------
    // Key bits
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pressed <= '0;
        end else if (keyValid) begin
            for (int col = 0; col < kbdPkg::keysPerRow; col++) begin
                if (kbdPkg::keyMap[BASE + col].code == keyCode) begin
                    // Break or wrong prefix clears the key
                    pressed[col] <= !keyRelease &&
                                    extAccepts(kbdPkg::keyMap[BASE + col].mode, keyExt);
                end
            end
        end
    end

    // Matrix starts with every key released
    assert property (@(posedge clk) !reset_n |=> pressed == '0)
        else $error("row %0d not cleared by reset", ROW);

endmodule

// File: hdl/matrixReadApb.sv
`timescale 1ns/1ps

module matrixReadApb (
    input  logic                                              clk,
    input  logic                                              reset_n,
    input  logic                                              psel,
    input  logic                                              penable,
    input  logic                                              pwrite,
    input  logic [7:0]                                        paddr,
    input  logic [kbdPkg::numRows-1:0][kbdPkg::keysPerRow-1:0] rowKeys,
    output logic [7:0]                                        prdata,
    output logic                                              pready,
    output logic                                              pslverr
);

    logic                          accessPhase;      // Setup seen last cycle
    logic                          inAccess;
    logic [kbdPkg::keysPerRow-1:0] colHeld;

    // --------------------------------------------------
    // APB phase tracking
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            accessPhase <= 1'b0;
        end else begin
            accessPhase <= psel && !penable;
        end
    end

    assign inAccess = accessPhase && psel && penable;
    assign pready   = inAccess;                      // No wait states
    assign pslverr  = inAccess && pwrite;            // Matrix is read-only

    // --------------------------------------------------
    // Column combine, a 0 in paddr selects a row
    // --------------------------------------------------
    always_comb begin
        colHeld = '0;
        for (int r = 0; r < kbdPkg::numRows; r++) begin
            if (!paddr[r]) begin
                colHeld = colHeld | rowKeys[r];
            end
        end
    end

    // Active low columns, like the Z88 keyboard port
    assign prdata = (inAccess && !pwrite) ? ~colHeld : 8'h00;

    assert property (@(posedge clk) disable iff (!reset_n) penable |-> psel)
        else $error("penable high without psel");

endmodule

// File: hdl/ps2Keyboard.sv
`timescale 1ns/1ps

module ps2Keyboard #(
    parameter int SYNC_STAGES    = 3,
    parameter int TIMEOUT_CYCLES = 2000
) (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       ps2clk,
    input  logic       ps2dat,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  logic [7:0] paddr,
    output logic [7:0] prdata,
    output logic       pready,
    output logic       pslverr
);

    logic [7:0] rxByte;
    logic       rxValid;
    logic [7:0] keyCode;
    logic       keyExt;
    logic       keyRelease;
    logic       keyValid;

    wire [kbdPkg::numRows-1:0][kbdPkg::keysPerRow-1:0] rowKeys;  // Held keys per row

    // --------------------------------------------------
    // PS/2 receive and decode
    // --------------------------------------------------
    ps2FrameRx #(
        .SYNC_STAGES    (SYNC_STAGES),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) frameRx_i (
        .clk     (clk),
        .reset_n (reset_n),
        .ps2clk  (ps2clk),
        .ps2dat  (ps2dat),
        .rxByte  (rxByte),
        .rxValid (rxValid)
    );

    scanDecoder decoder_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .rxByte     (rxByte),
        .rxValid    (rxValid),
        .keyCode    (keyCode),
        .keyExt     (keyExt),
        .keyRelease (keyRelease),
        .keyValid   (keyValid)
    );

    // --------------------------------------------------
    // Key matrix, one block per Z88 row
    // --------------------------------------------------
    for (genvar r = 0; r < kbdPkg::numRows; r++) begin : genRow
        matrixRow #(
            .ROW (r)
        ) row_i (
            .clk        (clk),
            .reset_n    (reset_n),
            .keyCode    (keyCode),
            .keyExt     (keyExt),
            .keyRelease (keyRelease),
            .keyValid   (keyValid),
            .pressed    (rowKeys[r])
        );
    end

    matrixReadApb apb_i (
        .clk     (clk),
        .reset_n (reset_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .rowKeys (rowKeys),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

endmodule

// File: verif/ps2KeyboardTb.sv
`timescale 1ns/1ps

module ps2KeyboardTb;

    logic        clk;
    logic        reset_n;
    logic        ps2clk;
    logic        ps2dat;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [7:0]  prdata;
    logic        pready;
    logic        pslverr;
    logic [63:0] modelHeld;                          // Index is row * 8 + column
    logic [31:0] rngState;
    logic [7:0]  rdData;
    logic        rdErr;
    int          idx;

    ps2Keyboard #(
        .SYNC_STAGES    (3),
        .TIMEOUT_CYCLES (200)
    ) ps2Keyboard_i (
        .clk (clk), .reset_n (reset_n), .ps2clk (ps2clk), .ps2dat (ps2dat),
        .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
        .prdata (prdata), .pready (pready), .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stopRun(input string line);
        $display("%s", line);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // --------------------------------------------------
    // Reference model of the Z88 matrix
    // --------------------------------------------------
    function automatic void modelKey(input logic [7:0] code, input logic ext, input logic rls);
        logic fits;
        for (int i = 0; i < 64; i++) begin
            if (kbdPkg::keyMap[i].code == code) begin
                case (kbdPkg::keyMap[i].mode)
                    kbdPkg::extOnly: fits = ext;
                    kbdPkg::extAny:  fits = 1'b1;
                    default:         fits = !ext;
                endcase
                modelHeld[i] = !rls && fits;         // Break always releases
            end
        end
    endfunction

    function automatic logic [7:0] expectCols(input logic [7:0] addr);
        logic [7:0] held;
        held = '0;
        for (int r = 0; r < 8; r++) begin
            if (!addr[r]) held |= modelHeld[r*8 +: 8];
        end
        return ~held;                                // Active low columns
    endfunction

    // --------------------------------------------------
    // PS/2 and APB drivers
    // --------------------------------------------------
    task automatic sendFrame(input logic [7:0] data, input logic badParity, input int numBits);
        logic [10:0] frame;
        frame = {1'b1, (~^data) ^ badParity, data, 1'b0};
        @(posedge clk);
        for (int i = 0; i < numBits; i++) begin
            ps2clk <= 1'b0;
            repeat (3) @(posedge clk);
            ps2dat <= frame[i];                      // Data moves while clock is low
            repeat (3) @(posedge clk);
            ps2clk <= 1'b1;
            repeat (6) @(posedge clk);
        end
        ps2dat <= 1'b1;
    endtask

    task automatic sendKey(input logic [7:0] code, input logic ext, input logic rls);
        if (ext) sendFrame(kbdPkg::extCode, 1'b0, 11);
        if (rls) sendFrame(kbdPkg::rlsCode, 1'b0, 11);
        sendFrame(code, 1'b0, 11);
        modelKey(code, ext, rls);
    endtask

    task automatic apbAccess(input logic wr, input logic [7:0] addr,
                             output logic [7:0] data, output logic err);
        int waitCount;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        waitCount = 0;
        do begin
            @(negedge clk);
            waitCount++;
            if (waitCount > 16) stopRun("APB transfer hung waiting for pready");
        end while (!pready);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic checkRead(input logic [7:0] addr);
        logic [7:0] data;
        logic       err;
        apbAccess(1'b0, addr, data, err);
        assert (data == expectCols(addr) && !err)
            else stopRun($sformatf("FAIL at %0t ns: paddr %h read %h pslverr %b, expected %h",
                                   $time, addr, data, err, expectCols(addr)));
    endtask

    task automatic checkAllRows();
        for (int r = 0; r < 8; r++) checkRead(8'(~(8'h01 << r)));
        checkRead(8'h00);
    endtask

    assert property (@(posedge clk) disable iff (!reset_n) (psel && penable) |-> pready)
        else stopRun($sformatf("FAIL at %0t ns: pready low in access phase", $time));
    assert property (@(posedge clk) disable iff (!reset_n) !psel |-> (!pready && !pslverr))
        else stopRun($sformatf("FAIL at %0t ns: pready or pslverr high while idle", $time));

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        reset_n   = 1'b0;
        ps2clk    = 1'b1;
        ps2dat    = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = 8'hFF;
        modelHeld = '0;
        rngState  = 32'h8445_2ddc;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;

        checkAllRows();                              // Empty matrix
        apbAccess(1'b1, 8'h00, rdData, rdErr);
        assert (rdErr) else stopRun($sformatf("FAIL at %0t ns: write without pslverr", $time));
        checkAllRows();

        sendKey(8'h1C, 1'b0, 1'b0);                  // A make, then break
        checkAllRows();
        sendKey(8'h1C, 1'b0, 1'b1);
        checkAllRows();

        sendKey(8'h75, 1'b1, 1'b0);                  // Up arrow needs E0
        checkAllRows();
        sendKey(8'h75, 1'b1, 1'b1);
        checkAllRows();
        sendKey(8'h75, 1'b0, 1'b0);
        checkAllRows();
        sendKey(8'h14, 1'b1, 1'b0);                  // Ctrl either way
        checkAllRows();
        sendKey(8'h14, 1'b0, 1'b1);
        checkAllRows();
        sendKey(8'h14, 1'b0, 1'b0);
        checkAllRows();

        sendFrame(8'h15, 1'b1, 11);                  // Bad parity is dropped
        checkAllRows();
        sendFrame(8'h15, 1'b0, 5);                   // Stalled frame
        repeat (220) @(posedge clk);
        sendKey(8'h15, 1'b0, 1'b0);
        checkAllRows();

        for (int n = 0; n < 40; n++) begin
            rngState = xorshift(rngState);
            idx = rngState[5:0];
            sendKey(kbdPkg::keyMap[idx].code, rngState[8], rngState[9]);
            rngState = xorshift(rngState);
            checkRead(rngState[7:0]);                // Random multi-row mask
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: ps2Keyboard.f
hdl/kbdPkg.sv
hdl/ps2FrameRx.sv
hdl/scanDecoder.sv
hdl/matrixRow.sv
hdl/matrixReadApb.sv
hdl/ps2Keyboard.sv
verif/ps2KeyboardTb.sv
